// ==== tb.f ====
rtl/rv_exec_pkg.sv
rtl/op_decoder.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/exec_result_mux.sv
rtl/exec_stage.sv
dv/exec_stage_sva.sv
dv/exec_stage_tb.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - files:
      - rtl/rv_exec_pkg.sv
      - rtl/op_decoder.sv
      - rtl/int_alu.sv
      - rtl/branch_unit.sv
      - rtl/exec_result_mux.sv
      - rtl/exec_stage.sv
  - target: simulation
    files:
      - dv/exec_stage_sva.sv
      - dv/exec_stage_tb.sv

// ==== dv/exec_stage_tb.sv ====
`default_nettype none

module exec_stage_tb
    import rv_exec_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int N_CYCLES        = 600;
    localparam int MID_RESET_AT    = N_CYCLES / 2;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_CYCLES + 3 + 3 + 100;   // Reset, run, tail

    // Operation classes, also used to name the failing test
    localparam int CLS_IDLE    = 0;
    localparam int CLS_ALU_REG = 1;
    localparam int CLS_ALU_IMM = 2;
    localparam int CLS_UPPER   = 3;
    localparam int CLS_BRANCH  = 4;
    localparam int CLS_JAL     = 5;
    localparam int CLS_JALR    = 6;
    localparam int CLS_NO_OP   = 7;
    localparam int CLS_RESET   = 8;

    logic        clk;
    logic        reset;
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    int          cur_cls;
    logic [31:0] rng_state = 32'he13f;
    logic        primed = 1'b0;                    // Set once the first reset edge is seen

    logic        now_wb_valid;
    logic [4:0]  now_wb_rd;
    logic [31:0] now_wb_data;
    logic        now_br_valid;
    logic [31:0] now_br_pc;
    logic        exp_wb_valid;
    logic [4:0]  exp_wb_rd;
    logic [31:0] exp_wb_data;
    logic        exp_br_valid;
    logic [31:0] exp_br_pc;
    int          cls_q;

    exec_stage i_exec_stage (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_valid          (valid),
        .i_instr          (instr),
        .i_pc             (pc),
        .i_rs1_val        (rs1_val),
        .i_rs2_val        (rs2_val),
        .o_wb_valid       (wb_valid),
        .o_wb_rd          (wb_rd),
        .o_wb_data        (wb_data),
        .o_redirect_valid (redirect_valid),
        .o_redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Corner values show up often to stress signed versus unsigned compares
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0: return 32'd0;
            3'd1: return 32'h8000_0000;
            3'd2: return 32'hffff_ffff;
            3'd3: return 32'h7fff_ffff;
            3'd4: return {27'd0, r[31:27]};
            default: return next_rand();
        endcase
    endfunction

    function automatic string class_name(input int cls);
        case (cls)
            CLS_ALU_REG: return "alu_reg";
            CLS_ALU_IMM: return "alu_imm";
            CLS_UPPER:   return "upper_imm";
            CLS_BRANCH:  return "branch";
            CLS_JAL:     return "jal";
            CLS_JALR:    return "jalr";
            CLS_NO_OP:   return "no_op";
            CLS_RESET:   return "reset";
            default:     return "idle";
        endcase
    endfunction

    // Result by funct3 as the ISA manual lists it
    function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'b000: return alt ? x - y : x + y;
            3'b001: return x << y[4:0];
            3'b010: return {31'd0, $signed(x) < $signed(y)};
            3'b011: return {31'd0, x < y};
            3'b100: return x ^ y;
            3'b101: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110: return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_holds(input logic [2:0] f3, input logic [31:0] x,
                                          input logic [31:0] y);
        case (f3)
            3'b000: return x == y;
            3'b001: return x != y;
            3'b100: return $signed(x) < $signed(y);
            3'b101: return $signed(x) >= $signed(y);
            3'b110: return x < y;
            default: return x >= y;
        endcase
    endfunction

    function automatic void ref_model(input logic v, input logic [31:0] word,
                                      input logic [31:0] p, input logic [31:0] x,
                                      input logic [31:0] y, output logic wb_v,
                                      output logic [4:0] wb_r, output logic [31:0] wb_d,
                                      output logic br_v, output logic [31:0] br_pc);
        rv_instr_u   ins;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic        writes;
        logic        taken;
        logic        alt;
        ins    = word;
        imm_i  = {{20{word[31]}}, word[31:20]};
        imm_b  = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        imm_u  = {word[31:12], 12'd0};
        imm_j  = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        writes = 1'b0;
        taken  = 1'b0;
        wb_d   = 32'd0;
        br_pc  = 32'd0;
        case (ins.r_fmt.opcode)
            OPC_OP: begin
                alt    = (ins.r_fmt.funct7 == 7'h20);
                writes = (ins.r_fmt.funct7 == 7'h00) ||
                         (alt && (ins.r_fmt.funct3 == 3'b000 || ins.r_fmt.funct3 == 3'b101));
                wb_d   = alu_calc(ins.r_fmt.funct3, alt, x, y);
            end
            OPC_OP_IMM: begin
                alt    = (ins.i_fmt.funct3 == 3'b101) && (ins.r_fmt.funct7 == 7'h20);
                writes = (ins.i_fmt.funct3[1:0] != 2'b01) || (ins.r_fmt.funct7 == 7'h00) || alt;
                wb_d   = alu_calc(ins.i_fmt.funct3, alt, x, imm_i);
            end
            OPC_LUI: begin
                writes = 1'b1;
                wb_d   = imm_u;
            end
            OPC_AUIPC: begin
                writes = 1'b1;
                wb_d   = p + imm_u;
            end
            OPC_BRANCH: begin
                taken = (ins.b_fmt.funct3[2:1] != 2'b01) && branch_holds(ins.b_fmt.funct3, x, y);
                br_pc = p + imm_b;
            end
            OPC_JAL: begin
                writes = 1'b1;
                taken  = 1'b1;
                wb_d   = p + 32'd4;
                br_pc  = p + imm_j;
            end
            OPC_JALR: begin
                if (ins.i_fmt.funct3 == 3'b000) begin
                    writes = 1'b1;
                    taken  = 1'b1;
                    wb_d   = p + 32'd4;
                    br_pc  = (x + imm_i) & ~32'd1;
                end
            end
            default: ;
        endcase
        wb_v = v && writes && (ins.r_fmt.rd != 5'd0);
        wb_r = ins.r_fmt.rd;
        br_v = v && taken;
    endfunction

    always_comb begin
        ref_model(valid, instr, pc, rs1_val, rs2_val,
                  now_wb_valid, now_wb_rd, now_wb_data, now_br_valid, now_br_pc);
    end

    // Expected outputs one cycle behind the inputs
    always @(posedge clk) begin
        if (reset) begin
            primed       <= 1'b1;
            exp_wb_valid <= 1'b0;
            exp_br_valid <= 1'b0;
            cls_q        <= CLS_RESET;
        end else begin
            exp_wb_valid <= now_wb_valid;
            exp_br_valid <= now_br_valid;
            cls_q        <= cur_cls;
        end
        exp_wb_rd   <= now_wb_rd;
        exp_wb_data <= now_wb_data;
        exp_br_pc   <= now_br_pc;
    end

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("** Error [%s] %s: expected 0x%08h, actual 0x%08h", test, what, expected, actual);
        $display("Errors found");
        $fatal(1);
    endtask

    chk_wb_valid: assert property (@(posedge clk) primed |-> wb_valid == exp_wb_valid)
        else report_mismatch(class_name($sampled(cls_q)), "wb_valid",
                             $sampled(exp_wb_valid), $sampled(wb_valid));
    chk_wb_rd: assert property (@(posedge clk) primed && exp_wb_valid |-> wb_rd == exp_wb_rd)
        else report_mismatch(class_name($sampled(cls_q)), "wb_rd",
                             $sampled(exp_wb_rd), $sampled(wb_rd));
    chk_wb_data: assert property (@(posedge clk) primed && exp_wb_valid |-> wb_data == exp_wb_data)
        else report_mismatch(class_name($sampled(cls_q)), "wb_data",
                             $sampled(exp_wb_data), $sampled(wb_data));
    chk_br_valid: assert property (@(posedge clk) primed |-> redirect_valid == exp_br_valid)
        else report_mismatch(class_name($sampled(cls_q)), "redirect_valid",
                             $sampled(exp_br_valid), $sampled(redirect_valid));
    chk_br_pc: assert property (@(posedge clk) primed && exp_br_valid |-> redirect_pc == exp_br_pc)
        else report_mismatch(class_name($sampled(cls_q)), "redirect_pc",
                             $sampled(exp_br_pc), $sampled(redirect_pc));
    chk_rst_rd: assert property (@(posedge clk) primed && $past(reset) |-> wb_rd == 5'd0)
        else report_mismatch("reset", "wb_rd", 32'd0, $sampled(wb_rd));
    chk_rst_data: assert property (@(posedge clk) primed && $past(reset) |-> wb_data == 32'd0)
        else report_mismatch("reset", "wb_data", 32'd0, $sampled(wb_data));
    chk_rst_pc: assert property (@(posedge clk) primed && $past(reset) |-> redirect_pc == 32'd0)
        else report_mismatch("reset", "redirect_pc", 32'd0, $sampled(redirect_pc));

    task automatic drive(input logic v, input logic [31:0] word, input logic [31:0] p,
                         input logic [31:0] a, input logic [31:0] b, input int cls);
        @(negedge clk);
        valid   = v;
        instr   = word;
        pc      = p;
        rs1_val = a;
        rs2_val = b;
        cur_cls = cls;
    endtask

    task automatic issue(input int cls);
        rv_instr_u   w;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        r = next_rand();
        a = pick_operand();
        b = pick_operand();
        p = next_rand() & 32'hffff_fffc;
        w = next_rand();                                // Random fields, fixed up below
        case (cls)
            CLS_ALU_REG: begin
                w.r_fmt.opcode = OPC_OP;
                w.r_fmt.funct3 = r[2:0];
                w.r_fmt.funct7 = (r[3] && (r[2:0] == 3'b000 || r[2:0] == 3'b101)) ? 7'h20 : 7'h00;
            end
            CLS_ALU_IMM: begin
                w.i_fmt.opcode = OPC_OP_IMM;
                w.i_fmt.funct3 = r[2:0];
                if (r[1:0] == 2'b01) begin
                    w.r_fmt.funct7 = (r[2] && r[3]) ? 7'h20 : 7'h00;   // SRAI only
                end
            end
            CLS_UPPER: begin
                w.u_fmt.opcode = r[0] ? OPC_LUI : OPC_AUIPC;
            end
            CLS_BRANCH: begin
                w.b_fmt.opcode = OPC_BRANCH;
                w.b_fmt.funct3 = (r[2:1] == 2'b01) ? 3'b000 : r[2:0];
                if (r[5:4] == 2'b00) begin
                    b = a;                              // Equal operands
                end
            end
            CLS_JAL: begin
                w.j_fmt.opcode = OPC_JAL;
            end
            CLS_JALR: begin
                w.i_fmt.opcode = OPC_JALR;
                w.i_fmt.funct3 = 3'b000;
            end
            default: begin
                case (r[2:0])
                    3'd0: w.r_fmt.opcode = 7'b0000011;  // Load
                    3'd1: w.r_fmt.opcode = 7'b0100011;  // Store
                    3'd2: w.r_fmt.opcode = 7'b0001111;  // Fence
                    3'd3: w.r_fmt.opcode = 7'b1110011;  // System
                    3'd4: begin
                        w.r_fmt.opcode = OPC_OP;
                        w.r_fmt.funct7 = 7'h01;         // M extension
                    end
                    3'd5: begin
                        w.b_fmt.opcode = OPC_BRANCH;
                        w.b_fmt.funct3 = 3'b010;
                    end
                    3'd6: begin
                        w.i_fmt.opcode = OPC_JALR;
                        w.i_fmt.funct3 = 3'b001;
                    end
                    default: begin
                        w.i_fmt.opcode = OPC_OP_IMM;
                        w.i_fmt.funct3 = 3'b001;
                        w.r_fmt.funct7 = 7'h20;         // Bad SLLI
                    end
                endcase
            end
        endcase
        if (r[9:7] == 3'd0) begin
            w.r_fmt.rd = 5'd0;
        end
        drive(1'b1, w, p, a, b, cls);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog timer expired, the run hung");
        $display("Errors found");
        $fatal(1);
    end

    always @(negedge clk) begin
        if (i_exec_stage.i_exec_stage_sva.fail_count != 0) begin
            $display("A bound protocol assertion on the DUT outputs failed");
            $display("Errors found");
            $fatal(1);
        end
    end

    initial begin
        logic [31:0] r;
        valid   = 1'b0;
        instr   = 32'd0;
        pc      = 32'd0;
        rs1_val = 32'd0;
        rs2_val = 32'd0;
        cur_cls = CLS_IDLE;
        reset   = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < N_CYCLES; n++) begin
            if (n == MID_RESET_AT) begin
                issue(CLS_JAL);                         // Jump stays in flight across the reset
                reset = 1'b1;
                repeat (2) @(negedge clk);
                reset = 1'b0;
            end
            r = next_rand();
            if (r[3:0] < 4'd3) begin
                drive(1'b0, next_rand(), next_rand(), next_rand(), next_rand(), CLS_IDLE);
            end else begin
                issue(int'(r[7:4]) % 7 + 1);
            end
        end
        repeat (3) drive(1'b0, 32'd0, 32'd0, 32'd0, 32'd0, CLS_IDLE);
        @(negedge clk);
        if (i_exec_stage.i_exec_stage_sva.fail_count != 0) begin
            $display("Errors found");
            $fatal(1);
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dv/exec_stage_sva.sv ====
`default_nettype none

module exec_stage_sva (
    input logic        i_clk,
    input logic        i_reset,
    input logic        i_wb_valid,
    input logic [4:0]  i_wb_rd,
    input logic        i_redirect_valid,
    input logic [31:0] i_redirect_pc
);

    int fail_count = 0;                            // Polled from the testbench top

    valids_low_after_reset: assert property (
        @(posedge i_clk) i_reset |=> !i_wb_valid && !i_redirect_valid)
        else begin
            fail_count = fail_count + 1;
            $error("Valid output high in the cycle after reset");
        end

    no_write_to_x0: assert property (@(posedge i_clk) i_wb_valid |-> i_wb_rd != 5'd0)
        else begin
            fail_count = fail_count + 1;
            $error("Write-back to register zero");
        end

    // Targets are at least halfword aligned
    redirect_bit0_clear: assert property (@(posedge i_clk) i_redirect_valid |-> !i_redirect_pc[0])
        else begin
            fail_count = fail_count + 1;
            $error("Redirect target with bit zero set");
        end

endmodule

bind exec_stage exec_stage_sva i_exec_stage_sva (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_wb_valid       (o_wb_valid),
    .i_wb_rd          (o_wb_rd),
    .i_redirect_valid (o_redirect_valid),
    .i_redirect_pc    (o_redirect_pc)
);

`default_nettype wire

// ==== rtl/exec_stage.sv ====
`default_nettype none

module exec_stage
    import rv_exec_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_valid,
    input  logic [31:0] i_instr,
    input  logic [31:0] i_pc,
    input  logic [31:0] i_rs1_val,
    input  logic [31:0] i_rs2_val,
    output logic        o_wb_valid,
    output logic [4:0]  o_wb_rd,
    output logic [31:0] o_wb_data,
    output logic        o_redirect_valid,
    output logic [31:0] o_redirect_pc
);

    exec_op_e    op;
    logic [31:0] imm;
    logic [4:0]  rd;
    logic        writes_rd;
    logic [31:0] alu_result;
    logic        br_taken;
    logic [31:0] br_target;

    op_decoder i_op_decoder (
        .i_instr     (i_instr),
        .o_op        (op),
        .o_imm       (imm),
        .o_rd        (rd),
        .o_writes_rd (writes_rd)
    );

    // ALU and branch unit see the same decoded operation in parallel
    int_alu i_int_alu (
        .i_op      (op),
        .i_rs1_val (i_rs1_val),
        .i_rs2_val (i_rs2_val),
        .i_imm     (imm),
        .i_pc      (i_pc),
        .o_result  (alu_result)
    );

    branch_unit i_branch_unit (
        .i_op      (op),
        .i_rs1_val (i_rs1_val),
        .i_rs2_val (i_rs2_val),
        .i_imm     (imm),
        .i_pc      (i_pc),
        .o_taken   (br_taken),
        .o_target  (br_target)
    );

    exec_result_mux i_exec_result_mux (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_valid          (i_valid),
        .i_writes_rd      (writes_rd),
        .i_rd             (rd),
        .i_result         (alu_result),
        .i_taken          (br_taken),
        .i_target         (br_target),
        .o_wb_valid       (o_wb_valid),
        .o_wb_rd          (o_wb_rd),
        .o_wb_data        (o_wb_data),
        .o_redirect_valid (o_redirect_valid),
        .o_redirect_pc    (o_redirect_pc)
    );

endmodule

`default_nettype wire

// ==== rtl/exec_result_mux.sv ====
`default_nettype none

module exec_result_mux (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_valid,
    input  logic        i_writes_rd,
    input  logic [4:0]  i_rd,
    input  logic [31:0] i_result,
    input  logic        i_taken,
    input  logic [31:0] i_target,
    output logic        o_wb_valid,
    output logic [4:0]  o_wb_rd,
    output logic [31:0] o_wb_data,
    output logic        o_redirect_valid,
    output logic [31:0] o_redirect_pc
);

    logic wb_fire;
    logic redirect_fire;

    // x0 is hardwired so writes to it are dropped here
    assign wb_fire       = i_valid && i_writes_rd && (i_rd != 5'd0);
    assign redirect_fire = i_valid && i_taken;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_valid       <= 1'b0;
            o_wb_rd          <= 5'd0;
            o_wb_data        <= 32'd0;
            o_redirect_valid <= 1'b0;
            o_redirect_pc    <= 32'd0;
        end else begin
            o_wb_valid       <= wb_fire;
            o_redirect_valid <= redirect_fire;
            if (wb_fire) begin
                o_wb_rd   <= i_rd;                        // Hold last write otherwise
                o_wb_data <= i_result;
            end
            if (redirect_fire) begin
                o_redirect_pc <= i_target;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/branch_unit.sv ====
`default_nettype none

module branch_unit
    import rv_exec_pkg::*;
(
    input  exec_op_e    i_op,
    input  logic [31:0] i_rs1_val,
    input  logic [31:0] i_rs2_val,
    input  logic [31:0] i_imm,
    input  logic [31:0] i_pc,
    output logic        o_taken,
    output logic [31:0] o_target
);

    logic        is_eq;
    logic        is_lt_s;
    logic        is_lt_u;
    logic [31:0] pc_rel;
    logic [31:0] reg_rel;

    assign is_eq   = (i_rs1_val == i_rs2_val);
    assign is_lt_s = ($signed(i_rs1_val) < $signed(i_rs2_val));
    assign is_lt_u = (i_rs1_val < i_rs2_val);

    assign pc_rel  = i_pc + i_imm;                        // Branches and JAL
    assign reg_rel = i_rs1_val + i_imm;

    // JALR drops bit zero of the sum
    assign o_target = (i_op == JALR) ? {reg_rel[31:1], 1'b0} : pc_rel;

    always_comb begin
        case (i_op)
            BEQ: begin
                o_taken = is_eq;
            end
            BNE: begin
                o_taken = !is_eq;
            end
            BLT: begin
                o_taken = is_lt_s;
            end
            BGE: begin
                o_taken = !is_lt_s;
            end
            BLTU: begin
                o_taken = is_lt_u;
            end
            BGEU: begin
                o_taken = !is_lt_u;
            end
            JAL, JALR: begin
                o_taken = 1'b1;                           // Always redirect
            end
            default: begin
                o_taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/int_alu.sv ====
`default_nettype none

module int_alu
    import rv_exec_pkg::*;
(
    input  exec_op_e    i_op,
    input  logic [31:0] i_rs1_val,
    input  logic [31:0] i_rs2_val,
    input  logic [31:0] i_imm,
    input  logic [31:0] i_pc,
    output logic [31:0] o_result
);

    logic [31:0] opnd_a;
    logic [31:0] opnd_b;
    logic [4:0]  shamt;
    logic        use_imm;

    // Immediate forms swap the immediate in for rs2
    assign use_imm = i_op inside {ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI};
    assign opnd_a  = i_rs1_val;
    assign opnd_b  = use_imm ? i_imm : i_rs2_val;
    assign shamt   = opnd_b[4:0];             // Upper bits ignored

    always_comb begin
        case (i_op)
            ADD, ADDI: begin
                o_result = opnd_a + opnd_b;
            end
            SUB: begin
                o_result = opnd_a - opnd_b;
            end
            SLL, SLLI: begin
                o_result = opnd_a << shamt;
            end
            SLT, SLTI: begin
                o_result = {31'd0, $signed(opnd_a) < $signed(opnd_b)};
            end
            SLTU, SLTIU: begin
                o_result = {31'd0, opnd_a < opnd_b};
            end
            XOR, XORI: begin
                o_result = opnd_a ^ opnd_b;
            end
            SRL, SRLI: begin
                o_result = opnd_a >> shamt;
            end
            SRA, SRAI: begin
                o_result = $unsigned($signed(opnd_a) >>> shamt);   // Keeps the sign
            end
            OR, ORI: begin
                o_result = opnd_a | opnd_b;
            end
            AND, ANDI: begin
                o_result = opnd_a & opnd_b;
            end
            LUI: begin
                o_result = i_imm;
            end
            AUIPC: begin
                o_result = i_pc + i_imm;
            end
            JAL, JALR: begin
                o_result = i_pc + 32'd4;              // Link address
            end
            default: begin
                o_result = 32'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/op_decoder.sv ====
`default_nettype none

module op_decoder
    import rv_exec_pkg::*;
(
    input  logic [31:0] i_instr,
    output exec_op_e    o_op,
    output logic [31:0] o_imm,
    output logic [4:0]  o_rd,
    output logic        o_writes_rd
);

    rv_instr_u   instr;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        f7_zero;
    logic        f7_alt;

    assign instr = i_instr;

    assign imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
    assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {instr.u_fmt.imm_31_12, 12'd0};
    assign imm_j = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                    instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

    // Shift-immediate forms reuse the funct7 slot of the I immediate
    assign f7_zero = (instr.r_fmt.funct7 == 7'b0000000);
    assign f7_alt  = (instr.r_fmt.funct7 == 7'b0100000);

    assign o_rd = instr.r_fmt.rd;

    always_comb begin
        o_op        = OP_NONE;
        o_imm       = 32'd0;
        o_writes_rd = 1'b0;
        case (instr.r_fmt.opcode)
            OPC_OP: begin
                case (instr.r_fmt.funct3)
                    3'b000: o_op = f7_zero ? ADD : (f7_alt ? SUB : OP_NONE);
                    3'b001: o_op = f7_zero ? SLL : OP_NONE;
                    3'b010: o_op = f7_zero ? SLT : OP_NONE;
                    3'b011: o_op = f7_zero ? SLTU : OP_NONE;
                    3'b100: o_op = f7_zero ? XOR : OP_NONE;
                    3'b101: o_op = f7_zero ? SRL : (f7_alt ? SRA : OP_NONE);
                    3'b110: o_op = f7_zero ? OR : OP_NONE;
                    default: o_op = f7_zero ? AND : OP_NONE;
                endcase
            end
            OPC_OP_IMM: begin
                o_imm = imm_i;
                case (instr.i_fmt.funct3)
                    3'b000: o_op = ADDI;
                    3'b001: o_op = f7_zero ? SLLI : OP_NONE;
                    3'b010: o_op = SLTI;
                    3'b011: o_op = SLTIU;
                    3'b100: o_op = XORI;
                    3'b101: o_op = f7_zero ? SRLI : (f7_alt ? SRAI : OP_NONE);
                    3'b110: o_op = ORI;
                    default: o_op = ANDI;
                endcase
            end
            OPC_LUI: begin
                o_op  = LUI;
                o_imm = imm_u;
            end
            OPC_AUIPC: begin
                o_op  = AUIPC;
                o_imm = imm_u;
            end
            OPC_BRANCH: begin
                o_imm = imm_b;
                case (instr.b_fmt.funct3)
                    3'b000: o_op = BEQ;
                    3'b001: o_op = BNE;
                    3'b100: o_op = BLT;
                    3'b101: o_op = BGE;
                    3'b110: o_op = BLTU;
                    3'b111: o_op = BGEU;
                    default: o_op = OP_NONE;     // 010 and 011 are reserved
                endcase
            end
            OPC_JAL: begin
                o_op  = JAL;
                o_imm = imm_j;
            end
            OPC_JALR: begin
                o_imm = imm_i;
                o_op  = (instr.i_fmt.funct3 == 3'b000) ? JALR : OP_NONE;
            end
            default: o_op = OP_NONE;
        endcase

        // Everything decoded except a branch writes a register
        o_writes_rd = (o_op != OP_NONE) && !(o_op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU});
    end

endmodule

`default_nettype wire

// ==== rtl/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    // Operations the execute stage knows how to perform
    typedef enum logic [5:0] {
        OP_NONE,        // Also covers loads, stores and bad encodings
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        ADDI,           // Immediate forms
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        LUI,
        AUIPC,
        BEQ,            // Conditional branches
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR
    } exec_op_e;

    // One instruction word seen through each RISC-V base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic       imm_12;      // Sign bit
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;      // Sign bit
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } rv_instr_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

`default_nettype wire
